// ==== files.f ====
hw/npc_pkg.sv
hw/npc_ifu.sv
hw/npc_idu.sv
hw/npc_regfile.sv
hw/npc_exu.sv
hw/npc_wbu.sv
hw/npc_top.sv
test/npc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the npc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module npc_tb \
    -Mdir obj_dir \
    -o npc_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/npc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// ==== test/npc_tb.sv ====
`timescale 1ns/1ps

module npc_tb
    import npc_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 5;
    localparam int RAND_STEPS   = 12;
    localparam int PROG_WORDS   = 64;

    logic            clk;
    logic            reset;
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic            halted;
    retire_t         retire;

    // program words by address and the retires they should produce
    logic [31:0]     prog [PROG_WORDS];
    retire_t         exp_q [$];
    logic [XLEN-1:0] xreg [32];
    logic [XLEN-1:0] mpc;

    integer seed;
    int     retire_errs;
    int     word_errs;
    int     bit_errs;
    int     n_steps = 0;

    npc_top i_dut (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .pc     (pc),
        .halted (halted),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        int limit;
        wait (n_steps > 0);
        limit = (n_steps + 2 * (RESET_CYCLES + 1 + HOLD_CYCLES) + 40) * 4;
        #(limit);
        $display("watchdog expired after %0d ns, the core did not finish its programs", limit);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_retire(input string name, input retire_t got, input retire_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            retire_errs++;
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            bit_errs++;
        end
    endtask

    function automatic logic [11:0] imm12(input int v);
        return v[11:0];
    endfunction

    function automatic logic [XLEN-1:0] sign_ext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic logic [XLEN-1:0] upper_imm(input logic [19:0] imm);
        return {{32{imm[19]}}, imm, 12'h000};
    endfunction

    // instruction formats from the base ISA
    function automatic logic [31:0] itype(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] utype(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b010:  return {63'd0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr < RESET_PC || idx >= 64'(PROG_WORDS)) begin
            return 32'h0;
        end
        return prog[idx[5:0]];
    endfunction

    // places one word at the model pc and predicts its retire record
    task automatic record_step(input logic [31:0] word, input logic [4:0] rd, input logic wr,
                               input logic [XLEN-1:0] val, input logic hlt, input logic ill,
                               input logic [XLEN-1:0] npc);
        retire_t r;
        logic [XLEN-1:0] idx;
        idx = (mpc - RESET_PC) >> 2;
        prog[idx[5:0]] = word;
        r.valid   = 1'b1;
        r.pc      = mpc;
        r.we      = wr && (rd != 5'd0);
        r.rd      = r.we ? rd : 5'd0;
        r.wdata   = r.we ? val : '0;
        r.halt    = hlt;
        r.illegal = ill;
        exp_q.push_back(r);
        if (r.we) begin
            xreg[rd] = val;
        end
        mpc = npc;
    endtask

    task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        record_step(itype(OP_IMM, f3, rd, rs1, imm), rd, 1'b1,
                    alu_model(f3, 1'b0, xreg[rs1], sign_ext12(imm)), 1'b0, 1'b0, mpc + 64'd4);
    endtask

    task automatic reg_op(input logic alt, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        record_step(rtype(alt ? 7'b0100000 : 7'b0000000, f3, rd, rs1, rs2), rd, 1'b1,
                    alu_model(f3, alt, xreg[rs1], xreg[rs2]), 1'b0, 1'b0, mpc + 64'd4);
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        record_step(utype(LUI, rd, imm), rd, 1'b1, upper_imm(imm), 1'b0, 1'b0, mpc + 64'd4);
    endtask

    task automatic add_upper_pc(input logic [4:0] rd, input logic [19:0] imm);
        record_step(utype(AUIPC, rd, imm), rd, 1'b1, mpc + upper_imm(imm), 1'b0, 1'b0,
                    mpc + 64'd4);
    endtask

    task automatic jump_link(input logic [4:0] rd, input logic [20:0] off);
        record_step(jtype(rd, off), rd, 1'b1, mpc + 64'd4, 1'b0, 1'b0,
                    mpc + {{43{off[20]}}, off});
    endtask

    // target uses rs1 before the link write
    task automatic jump_reg(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        record_step(itype(JALR, 3'b000, rd, rs1, imm), rd, 1'b1, mpc + 64'd4, 1'b0, 1'b0,
                    (xreg[rs1] + sign_ext12(imm)) & ~64'd1);
    endtask

    task automatic halt_break();
        record_step(32'h0010_0073, 5'd0, 1'b0, '0, 1'b1, 1'b0, mpc);
    endtask

    task automatic illegal_word(input logic [31:0] word);
        record_step(word, 5'd0, 1'b0, '0, 1'b1, 1'b1, mpc);
    endtask

    task automatic clear_model();
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = 32'h0;
        end
        exp_q.delete();
        mpc = RESET_PC;
    endtask

    task automatic build_directed();
        imm_op(3'b000, 5'd1, 5'd0, imm12(5));
        imm_op(3'b000, 5'd2, 5'd0, imm12(-3));
        reg_op(1'b0, 3'b000, 5'd3, 5'd1, 5'd2);
        reg_op(1'b1, 3'b000, 5'd4, 5'd2, 5'd1);
        // -8 < 5 only when signed
        reg_op(1'b0, 3'b010, 5'd5, 5'd4, 5'd1);
        imm_op(3'b010, 5'd6, 5'd1, imm12(-1));
        imm_op(3'b111, 5'd7, 5'd2, imm12(240));
        reg_op(1'b0, 3'b110, 5'd8, 5'd1, 5'd2);
        reg_op(1'b0, 3'b100, 5'd9, 5'd1, 5'd2);
        imm_op(3'b110, 5'd10, 5'd1, imm12(1792));
        imm_op(3'b100, 5'd11, 5'd2, imm12(-1));
        reg_op(1'b0, 3'b111, 5'd12, 5'd3, 5'd4);
        imm_op(3'b000, 5'd0, 5'd1, imm12(7));
        reg_op(1'b0, 3'b000, 5'd13, 5'd0, 5'd1);
        load_upper(5'd14, 20'h80001);
        add_upper_pc(5'd15, 20'h12345);
        jump_link(5'd16, 21'd12);
        imm_op(3'b000, 5'd17, 5'd16, imm12(1));
        add_upper_pc(5'd18, 20'h00000);
        // odd offset whose target loses bit 0
        jump_reg(5'd19, 5'd18, imm12(13));
        reg_op(1'b0, 3'b000, 5'd20, 5'd19, 5'd17);
        halt_break();
    endtask

    task automatic build_random();
        logic [31:0] r;
        for (int i = 0; i < RAND_STEPS; i++) begin
            r = $random(seed);
            if (r[31]) begin
                imm_op(3'b000, r[4:0], r[9:5], r[21:10]);
            end else begin
                reg_op(1'b0, 3'b000, r[4:0], r[9:5], r[14:10]);
            end
        end
        illegal_word(32'h0);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        inst  = 32'h0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            #1;
            check_bit("retire.valid", retire.valid, 1'b0);
            check_bit("halted", halted, 1'b0);
        end
    endtask

    task automatic run_program();
        for (int i = 0; i < exp_q.size(); i++) begin
            @(negedge clk);
            reset = 1'b0;
            inst  = fetch_word(pc);
            #1;
            check_retire("retire", retire, exp_q[i]);
            check_bit("halted", halted, 1'b0);
        end
        // core must stay parked on the halting word
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            inst = fetch_word(pc);
            #1;
            check_bit("halted", halted, 1'b1);
            check_bit("retire.valid", retire.valid, 1'b0);
            check_word("pc", pc, exp_q[exp_q.size() - 1].pc);
        end
    endtask

    initial begin
        int len1;
        seed        = 7595;
        reset       = 1'b1;
        inst        = 32'h0;
        retire_errs = 0;
        word_errs   = 0;
        bit_errs    = 0;
        clear_model();
        build_directed();
        len1    = exp_q.size();
        n_steps = len1 + RAND_STEPS + 1;
        apply_reset();
        run_program();
        clear_model();
        build_random();
        apply_reset();
        run_program();
        $display("error counts: retire %0d, word %0d, bit %0d", retire_errs, word_errs, bit_errs);
        if (retire_errs + word_errs + bit_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/npc_top.sv ====
`timescale 1ns/1ps

module npc_top
    import npc_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     inst,
    output logic [XLEN-1:0] pc,
    output logic            halted,
    output retire_t         retire
);

    fetch_t          fetch;
    decode_t         dec;
    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] alu_result;
    logic            wen;
    logic [4:0]      waddr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] next_pc;
    logic            halt_req;

    npc_ifu i_ifu (
        .clk      (clk),
        .reset    (reset),
        .inst     (inst),
        .next_pc  (next_pc),
        .halt_req (halt_req),
        .pc       (pc),
        .halted   (halted),
        .fetch    (fetch)
    );

    npc_idu i_idu (
        .fetch  (fetch),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .dec    (dec)
    );

    npc_regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .waddr  (waddr),
        .wen    (wen),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    npc_exu i_exu (
        .dec        (dec),
        .alu_result (alu_result)
    );

    npc_wbu i_wbu (
        .dec        (dec),
        .alu_result (alu_result),
        .wen        (wen),
        .waddr      (waddr),
        .wdata      (wdata),
        .next_pc    (next_pc),
        .halt_req   (halt_req),
        .retire     (retire)
    );

endmodule

// ==== hw/npc_wbu.sv ====
`timescale 1ns/1ps

module npc_wbu
    import npc_pkg::*;
(
    input  decode_t         dec,
    input  logic [XLEN-1:0] alu_result,
    output logic            wen,
    output logic [4:0]      waddr,
    output logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] next_pc,
    output logic            halt_req,
    output retire_t         retire
);

    logic do_write;

    // writes to x0 are dropped here
    assign do_write = dec.valid && dec.we && (dec.rd != 5'd0);

    assign wen      = do_write;
    assign waddr    = dec.rd;
    assign wdata    = alu_result;
    assign next_pc  = dec.next_pc;
    assign halt_req = dec.valid && (dec.is_ebreak || dec.is_illegal);

    // rd and wdata read as zero when nothing is written
    assign retire.valid   = dec.valid;
    assign retire.pc      = dec.pc;
    assign retire.rd      = do_write ? dec.rd : 5'd0;
    assign retire.we      = do_write;
    assign retire.wdata   = do_write ? alu_result : '0;
    assign retire.halt    = halt_req;
    assign retire.illegal = dec.valid && dec.is_illegal;

    always_comb begin
        if (retire.valid && retire.halt) begin
            a_halt_no_write: assert (!retire.we);
        end
        // link value comes from decode source selects through the alu
        if (dec.valid && dec.is_jump) begin
            a_jump_link: assert (alu_result == dec.pc + 64'd4);
        end
    end

endmodule

// ==== hw/npc_exu.sv ====
`timescale 1ns/1ps

module npc_exu
    import npc_pkg::*;
(
    input  decode_t         dec,
    output logic [XLEN-1:0] alu_result
);

    logic slt;

    assign slt = $signed(dec.src1) < $signed(dec.src2);

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:   alu_result = dec.src1 + dec.src2;
            ALU_SUB:   alu_result = dec.src1 - dec.src2;
            ALU_SLT:   alu_result = {{(XLEN-1){1'b0}}, slt};
            ALU_AND:   alu_result = dec.src1 & dec.src2;
            ALU_OR:    alu_result = dec.src1 | dec.src2;
            ALU_XOR:   alu_result = dec.src1 ^ dec.src2;
            // lui passes the upper immediate through
            ALU_COPY2: alu_result = dec.src2;
            default:   alu_result = '0;
        endcase
    end

    // decode must only hand over known operations
    always_comb begin
        if (dec.valid) begin
            a_alu_op_known: assert (dec.alu_op inside {
                ALU_ADD, ALU_SUB, ALU_SLT, ALU_AND, ALU_OR, ALU_XOR, ALU_COPY2
            });
        end
    end

endmodule

// ==== hw/npc_regfile.sv ====
`timescale 1ns/1ps

module npc_regfile
    import npc_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    input  logic [4:0]      waddr,
    input  logic            wen,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired and a write is not forwarded
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== hw/npc_idu.sv ====
`timescale 1ns/1ps

module npc_idu
    import npc_pkg::*;
(
    input  fetch_t          fetch,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    output logic [4:0]      raddr1,
    output logic [4:0]      raddr2,
    output decode_t         dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    npc_sel_e  npc_sel;
    logic      rf_we;
    logic      is_ebreak;
    logic      is_illegal;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jal_pc;
    logic [XLEN-1:0] jalr_pc;

    assign opcode = fetch.inst[6:0];
    assign rd     = fetch.inst[11:7];
    assign funct3 = fetch.inst[14:12];
    assign raddr1 = fetch.inst[19:15];
    assign raddr2 = fetch.inst[24:20];
    assign funct7 = fetch.inst[31:25];

    // sign-extended immediates
    assign imm_i = {{52{fetch.inst[31]}}, fetch.inst[31:20]};
    assign imm_u = {{32{fetch.inst[31]}}, fetch.inst[31:12], 12'b0};
    assign imm_j = {{43{fetch.inst[31]}}, fetch.inst[31], fetch.inst[19:12],
                    fetch.inst[20], fetch.inst[30:21], 1'b0};

    always_comb begin
        alu_op     = ALU_ADD;
        src1_sel   = SRC1_REG;
        src2_sel   = SRC2_REG;
        npc_sel    = NPC_PLUS4;
        rf_we      = 1'b0;
        is_ebreak  = 1'b0;
        is_illegal = 1'b0;
        case (opcode)
            OP_IMM: begin
                src2_sel = SRC2_IMMI;
                rf_we    = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    is_illegal = 1'b1;
                endcase
            end
            OP: begin
                rf_we = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD_SUB}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_SLT}:     alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:      alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     alu_op = ALU_AND;
                    default:               is_illegal = 1'b1;
                endcase
            end
            LUI: begin
                src1_sel = SRC1_ZERO;
                src2_sel = SRC2_IMMU;
                alu_op   = ALU_COPY2;
                rf_we    = 1'b1;
            end
            AUIPC: begin
                src1_sel = SRC1_PC;
                src2_sel = SRC2_IMMU;
                rf_we    = 1'b1;
            end
            JAL: begin
                // alu forms the link value pc + 4
                src1_sel = SRC1_PC;
                src2_sel = SRC2_FOUR;
                npc_sel  = NPC_JAL;
                rf_we    = 1'b1;
            end
            JALR: begin
                src1_sel = SRC1_PC;
                src2_sel = SRC2_FOUR;
                npc_sel  = NPC_JALR;
                rf_we    = 1'b1;
                if (funct3 != F3_JALR) begin
                    is_illegal = 1'b1;
                end
            end
            SYSTEM: begin
                if (fetch.inst == INST_EBREAK) begin
                    is_ebreak = 1'b1;
                end else begin
                    is_illegal = 1'b1;
                end
            end
            default: is_illegal = 1'b1;
        endcase
        // an illegal word must not touch the register file
        if (is_illegal) begin
            rf_we   = 1'b0;
            npc_sel = NPC_PLUS4;
        end
    end

    assign pc_plus4 = fetch.pc + 64'd4;
    assign jal_pc   = fetch.pc + imm_j;
    assign jalr_pc  = (rdata1 + imm_i) & ~64'd1;

    always_comb begin
        case (src1_sel)
            SRC1_PC:   dec.src1 = fetch.pc;
            SRC1_ZERO: dec.src1 = '0;
            default:   dec.src1 = rdata1;
        endcase
        case (src2_sel)
            SRC2_IMMI: dec.src2 = imm_i;
            SRC2_IMMU: dec.src2 = imm_u;
            SRC2_FOUR: dec.src2 = 64'd4;
            default:   dec.src2 = rdata2;
        endcase
        case (npc_sel)
            NPC_JAL:  dec.next_pc = jal_pc;
            NPC_JALR: dec.next_pc = jalr_pc;
            default:  dec.next_pc = pc_plus4;
        endcase
    end

    assign dec.alu_op     = alu_op;
    assign dec.rd         = rd;
    assign dec.we         = rf_we;
    assign dec.is_jump    = (npc_sel != NPC_PLUS4);
    assign dec.is_ebreak  = is_ebreak;
    assign dec.is_illegal = is_illegal;
    assign dec.pc         = fetch.pc;
    assign dec.valid      = fetch.valid;

endmodule

// ==== hw/npc_ifu.sv ====
`timescale 1ns/1ps

module npc_ifu
    import npc_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] next_pc,
    input  logic            halt_req,
    output logic [XLEN-1:0] pc,
    output logic            halted,
    output fetch_t          fetch
);

    logic [XLEN-1:0] pc_q;
    logic            halted_q;

    // pc stays on the halting instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q     <= RESET_PC;
            halted_q <= 1'b0;
        end else if (!halted_q) begin
            if (halt_req) begin
                halted_q <= 1'b1;
            end else begin
                pc_q <= next_pc;
            end
        end
    end

    assign pc     = pc_q;
    assign halted = halted_q;

    assign fetch.pc    = pc_q;
    assign fetch.inst  = inst;
    assign fetch.valid = !reset && !halted_q;

    // no compressed ISA, so a jump target must land on a word
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00
    );

endmodule

// ==== hw/npc_pkg.sv ====
package npc_pkg;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // funct fields used by the supported integer ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_AND   = 4'd3,
        ALU_OR    = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_COPY2 = 4'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_REG  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_REG  = 2'd0,
        SRC2_IMMI = 2'd1,
        SRC2_IMMU = 2'd2,
        SRC2_FOUR = 2'd3
    } src2_sel_e;

    typedef enum logic [1:0] {
        NPC_PLUS4 = 2'd0,
        NPC_JAL   = 2'd1,
        NPC_JALR  = 2'd2
    } npc_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic            valid;
    } fetch_t;

    typedef struct packed {
        alu_op_e         alu_op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic [4:0]      rd;
        logic            we;
        logic            is_jump;
        logic            is_ebreak;
        logic            is_illegal;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc;
        logic            valid;
    } decode_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] wdata;
        logic            halt;
        logic            illegal;
    } retire_t;

endpackage
